// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_core_kernel
FILELIST  = core_kernel.f
LOG       = sim.log
FAIL_MSG  = Done: errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== backend_reg_bank.sv ====
module backend_reg_bank import core_kernel_pkg::*; (
  input  logic                                 core_ctrl_clk,
  input  logic                                 core_ctrl_rst,
  ctrlport_if.responder                        bus,
  // Device identifier, already in this clock domain
  input  device_id_t                           device_id,
  // Backend config and status, one BACKEND_WIDTH slice per block
  output logic [NUM_BLOCKS*BACKEND_WIDTH-1:0]  block_config,
  input  logic [NUM_BLOCKS*BACKEND_WIDTH-1:0]  block_status
);

  // Offset split, bits 7:6 slot and 5:2 word
  slot_idx_t  slot;
  reg_idx_t   ridx;
  device_id_t device_id_q;

  // Writable config words for every slot
  ctrl_data_t config_q [NUM_SLOTS][REGS_PER_SLOT];
  // Read-only status words for every slot
  ctrl_data_t status_arr [NUM_SLOTS][REGS_PER_SLOT];

  assign slot = bus.offset[7:6];
  assign ridx = bus.offset[5:2];

  // Plain register stage on the device identifier
  always_ff @(posedge core_ctrl_clk) begin
    device_id_q <= device_id;
  end

  // -------------------------------------------------------------------------
  // Status map
  // -------------------------------------------------------------------------

  always_comb begin
    // Unused slots and registers read as zero
    for (int s = 0; s < NUM_SLOTS; s++) begin
      for (int r = 0; r < REGS_PER_SLOT; r++) begin
        status_arr[s][r] = '0;
      end
    end

    // Slot 0 carries the global identity registers
    status_arr[0][REG_GLOBAL_PROTOVER] = {CORE_SIGNATURE, PROTOVER};
    // Static-router flag is set when any edge exists
    status_arr[0][REG_GLOBAL_PORT_CNT] = {
      (NUM_EDGES != 12'd0),
      CHDR_XBAR_PRESENT,
      NUM_TRANSPORTS,
      NUM_BLOCKS,
      NUM_STREAM_ENDPOINTS
    };
    status_arr[0][REG_GLOBAL_EDGE_CNT]          = {20'd0, NUM_EDGES};
    status_arr[0][REG_GLOBAL_DEVICE_INFO]       = {DEVICE_TYPE, device_id_q};
    status_arr[0][REG_GLOBAL_ENDPOINT_CTRL_CNT] = {22'd0, NUM_ENDPOINTS_CTRL};

    // Block slots come from outside the core
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      for (int r = 0; r < REGS_PER_SLOT; r++) begin
        status_arr[b + BLOCK_OFFSET][r] =
          block_status[b*BACKEND_WIDTH + r*$bits(ctrl_data_t) +: $bits(ctrl_data_t)];
      end
    end
  end

  // -------------------------------------------------------------------------
  // Config registers and ack
  // -------------------------------------------------------------------------

  always_ff @(posedge core_ctrl_clk) begin
    if (core_ctrl_rst) begin
      bus.ack <= 1'b0;
      // Every slot starts from the same default table
      for (int s = 0; s < NUM_SLOTS; s++) begin
        for (int r = 0; r < REGS_PER_SLOT; r++) begin
          config_q[s][r] <= CONFIG_DEFAULT[r];
        end
      end
    end else begin
      // Single-cycle response for reads and writes
      bus.ack <= bus.wr || bus.rd;
      if (bus.wr) begin
        config_q[slot][ridx] <= bus.data;
      end
    end
  end

  // Read data, writes answer zero
  always_ff @(posedge core_ctrl_clk) begin
    if (bus.rd) begin
      bus.resp_data <= status_arr[slot][ridx];
    end else begin
      bus.resp_data <= '0;
    end
  end

  // Only block slots leave the core
  for (genvar b = 0; b < NUM_BLOCKS; b++) begin : g_blk
    for (genvar r = 0; r < REGS_PER_SLOT; r++) begin : g_reg
      assign block_config[b*BACKEND_WIDTH + r*$bits(ctrl_data_t) +: $bits(ctrl_data_t)] =
        config_q[b + BLOCK_OFFSET][r];
    end
  end

  // Router never strobes a read and a write together
  a_no_wr_and_rd: assert property (@(posedge core_ctrl_clk)
    disable iff (core_ctrl_rst)
    !(bus.wr && bus.rd));

endmodule

// ==== core_kernel.f ====
core_kernel_pkg.sv
ctrlport_if.sv
core_req_router.sv
backend_reg_bank.sv
edge_table_rom.sv
core_kernel_top.sv
tb_core_kernel.sv

// ==== core_kernel_pkg.sv ====
package core_kernel_pkg;

  // -------------------------------------------------------------------------
  // Vector types
  // -------------------------------------------------------------------------

  // Full control-port address, region nibble on top
  typedef logic [19:0] ctrl_addr_t;
  // One register word
  typedef logic [31:0] ctrl_data_t;
  // Byte offset inside one region
  typedef logic [15:0] reg_offset_t;
  // Slot number and register index inside the block region
  typedef logic [1:0]  slot_idx_t;
  typedef logic [3:0]  reg_idx_t;
  // Device identifier reported to software
  typedef logic [15:0] device_id_t;

  // -------------------------------------------------------------------------
  // Slot layout
  // -------------------------------------------------------------------------

  localparam logic [9:0] NUM_BLOCKS           = 10'd2;
  localparam logic [9:0] NUM_STREAM_ENDPOINTS = 10'd1;
  localparam logic [9:0] NUM_ENDPOINTS_CTRL   = 10'd1;
  localparam logic [9:0] NUM_TRANSPORTS       = 10'd1;
  // Core slot first, then stream endpoints, then processing blocks
  localparam int NUM_SLOTS     = 1 + NUM_STREAM_ENDPOINTS + NUM_BLOCKS;
  localparam int BLOCK_OFFSET  = 1 + NUM_STREAM_ENDPOINTS;
  localparam int REGS_PER_SLOT = 16;
  // 16 words of 32 bits per block
  localparam int BACKEND_WIDTH = 512;

  // Static connection table, header word plus one word per edge
  localparam logic [11:0] NUM_EDGES     = 12'd3;
  localparam int          EDGE_IDX_W    = $clog2(NUM_EDGES + 1);
  localparam              EDGE_TBL_FILE = "edge_table.hex";

  // Identity of this core
  localparam logic [15:0] PROTOVER          = {8'd1, 8'd0};
  localparam logic [15:0] CORE_SIGNATURE    = 16'h12C6;
  localparam logic [15:0] DEVICE_TYPE       = 16'hA300;
  localparam logic        CHDR_XBAR_PRESENT = 1'b1;

  // Reset value of each config register, indexed by register number
  localparam ctrl_data_t CONFIG_DEFAULT [REGS_PER_SLOT] = '{
    32'h0000_0001, 32'h0000_0000, 32'h0000_0040, 32'h0000_0000,
    32'h0000_0000, 32'h0000_00FF, 32'h0000_0000, 32'h0000_0000,
    32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF
  };

  // -------------------------------------------------------------------------
  // Address map
  // -------------------------------------------------------------------------

  // Region nibble, address bits 19:16
  localparam logic [3:0] REGION_BLOCK = 4'd0;
  localparam logic [3:0] REGION_CONN  = 4'd1;

  // Global registers of slot 0
  localparam reg_idx_t REG_GLOBAL_PROTOVER          = 4'd0;
  localparam reg_idx_t REG_GLOBAL_PORT_CNT          = 4'd1;
  localparam reg_idx_t REG_GLOBAL_EDGE_CNT          = 4'd2;
  localparam reg_idx_t REG_GLOBAL_DEVICE_INFO       = 4'd3;
  localparam reg_idx_t REG_GLOBAL_ENDPOINT_CTRL_CNT = 4'd4;

endpackage

// ==== core_kernel_top.sv ====
module core_kernel_top import core_kernel_pkg::*; (
  input  logic                                core_ctrl_clk,
  input  logic                                core_ctrl_rst,
  // Control port, fixed 3-cycle request to ack
  input  logic                                req_wr,
  input  logic                                req_rd,
  input  ctrl_addr_t                          req_addr,
  input  ctrl_data_t                          req_data,
  output logic                                resp_ack,
  output ctrl_data_t                          resp_data,
  // Global info
  input  device_id_t                          device_id,
  // Backend config and status of the processing blocks
  output logic [NUM_BLOCKS*BACKEND_WIDTH-1:0] block_config,
  input  logic [NUM_BLOCKS*BACKEND_WIDTH-1:0] block_status
);

  // Block space channel
  ctrlport_if blk_bus ();
  // Connection space channel
  ctrlport_if conn_bus ();

  // -------------------------------------------------------------------------
  // Address split and response merge
  // -------------------------------------------------------------------------

  core_req_router u_router (
    .core_ctrl_clk (core_ctrl_clk),
    .core_ctrl_rst (core_ctrl_rst),
    .req_wr        (req_wr),
    .req_rd        (req_rd),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .resp_ack      (resp_ack),
    .resp_data     (resp_data),
    .blk_bus       (blk_bus),
    .conn_bus      (conn_bus)
  );

  // -------------------------------------------------------------------------
  // Responders
  // -------------------------------------------------------------------------

  // Config, status and global identity
  backend_reg_bank u_reg_bank (
    .core_ctrl_clk (core_ctrl_clk),
    .core_ctrl_rst (core_ctrl_rst),
    .bus           (blk_bus),
    .device_id     (device_id),
    .block_config  (block_config),
    .block_status  (block_status)
  );

  // Topology discovery
  edge_table_rom u_edge_rom (
    .core_ctrl_clk (core_ctrl_clk),
    .core_ctrl_rst (core_ctrl_rst),
    .bus           (conn_bus)
  );

endmodule

// ==== core_req_router.sv ====
module core_req_router import core_kernel_pkg::*; (
  input  logic          core_ctrl_clk,
  input  logic          core_ctrl_rst,
  // Control port from the requester
  input  logic          req_wr,
  input  logic          req_rd,
  input  ctrl_addr_t    req_addr,
  input  ctrl_data_t    req_data,
  output logic          resp_ack,
  output ctrl_data_t    resp_data,
  // Sub-channels to the two responders
  ctrlport_if.requester blk_bus,
  ctrlport_if.requester conn_bus
);

  // Region decode
  logic [3:0]  region;
  logic        hit_blk;
  logic        hit_conn;
  logic        hit_unm;
  logic        req_any;

  // Registered sub-strobes
  logic        blk_wr_q;
  logic        blk_rd_q;
  logic        conn_wr_q;
  logic        conn_rd_q;
  // Unmapped stage, stands in for a responder
  logic        unm_req_q;
  logic        unm_ack_q;

  // Offset and data shared by both channels
  reg_offset_t offset_q;
  ctrl_data_t  data_q;

  // -------------------------------------------------------------------------
  // Request side, edge T+1
  // -------------------------------------------------------------------------

  assign region   = req_addr[19:16];
  assign hit_blk  = (region == REGION_BLOCK);
  assign hit_conn = (region == REGION_CONN);
  // Everything above the two regions
  assign hit_unm  = !hit_blk && !hit_conn;
  assign req_any  = req_wr || req_rd;

  always_ff @(posedge core_ctrl_clk) begin
    if (core_ctrl_rst) begin
      blk_wr_q  <= 1'b0;
      blk_rd_q  <= 1'b0;
      conn_wr_q <= 1'b0;
      conn_rd_q <= 1'b0;
      unm_req_q <= 1'b0;
      unm_ack_q <= 1'b0;
    end else begin
      blk_wr_q  <= req_wr && hit_blk;
      blk_rd_q  <= req_rd && hit_blk;
      conn_wr_q <= req_wr && hit_conn;
      conn_rd_q <= req_rd && hit_conn;
      unm_req_q <= req_any && hit_unm;
      // One extra stage so unmapped requests keep the 3-cycle latency
      unm_ack_q <= unm_req_q;
    end
  end

  // Lower 16 address bits go out as the region offset
  always_ff @(posedge core_ctrl_clk) begin
    offset_q <= req_addr[15:0];
    data_q   <= req_data;
  end

  assign blk_bus.wr      = blk_wr_q;
  assign blk_bus.rd      = blk_rd_q;
  assign blk_bus.offset  = offset_q;
  assign blk_bus.data    = data_q;
  assign conn_bus.wr     = conn_wr_q;
  assign conn_bus.rd     = conn_rd_q;
  assign conn_bus.offset = offset_q;
  assign conn_bus.data   = data_q;

  // -------------------------------------------------------------------------
  // Response merge, edge T+3
  // -------------------------------------------------------------------------

  always_ff @(posedge core_ctrl_clk) begin
    if (core_ctrl_rst) begin
      resp_ack  <= 1'b0;
      resp_data <= '0;
    end else begin
      resp_ack <= blk_bus.ack || conn_bus.ack || unm_ack_q;
      // Unmapped and idle cycles give zero
      if (blk_bus.ack) begin
        resp_data <= blk_bus.resp_data;
      end else if (conn_bus.ack) begin
        resp_data <= conn_bus.resp_data;
      end else begin
        resp_data <= '0;
      end
    end
  end

  // Same latency on every path, so answers never collide
  a_one_ack_source: assert property (@(posedge core_ctrl_clk) disable iff (core_ctrl_rst)
    $onehot0({blk_bus.ack, conn_bus.ack, unm_ack_q}));

  // Requester never issues a read and a write together
  a_no_wr_and_rd: assert property (@(posedge core_ctrl_clk) disable iff (core_ctrl_rst)
    !(req_wr && req_rd));

endmodule

// ==== ctrlport_if.sv ====
interface ctrlport_if import core_kernel_pkg::*; ();

  // Request, a single-cycle pulse on wr or rd
  logic        wr;
  logic        rd;
  reg_offset_t offset;
  ctrl_data_t  data;

  // Response, one ack pulse per request
  logic        ack;
  // Valid with ack, zero for writes
  ctrl_data_t  resp_data;

  modport requester (
    output wr,
    output rd,
    output offset,
    output data,
    input  ack,
    input  resp_data
  );

  modport responder (
    input  wr,
    input  rd,
    input  offset,
    input  data,
    output ack,
    output resp_data
  );

endinterface

// ==== edge_table.hex ====
// Word 0 holds the edge count, one edge per following word
// Edge word {src blk [31:22], src port [21:16], dst blk [15:6], dst port [5:0]}
00000003
00400080
008100C0
00C00040

// ==== edge_table_rom.sv ====
module edge_table_rom import core_kernel_pkg::*; (
  input  logic          core_ctrl_clk,
  input  logic          core_ctrl_rst,
  ctrlport_if.responder bus
);

  // Word 0 header with the entry count, then one word per edge
  // {src blk 10b, src port 6b, dst blk 10b, dst port 6b}
  ctrl_data_t  rom [0:NUM_EDGES];

  // Word index from the byte offset
  logic [13:0] word_idx;
  logic        in_table;

  initial begin
    $readmemh(EDGE_TBL_FILE, rom);
  end

  assign word_idx = bus.offset[15:2];
  // Past the last edge reads zero
  assign in_table = (word_idx <= NUM_EDGES);

  // -------------------------------------------------------------------------
  // Response
  // -------------------------------------------------------------------------

  always_ff @(posedge core_ctrl_clk) begin
    if (core_ctrl_rst) begin
      bus.ack <= 1'b0;
    end else begin
      // Writes are acked and dropped
      bus.ack <= bus.wr || bus.rd;
    end
  end

  always_ff @(posedge core_ctrl_clk) begin
    if (bus.rd && in_table) begin
      bus.resp_data <= rom[word_idx[EDGE_IDX_W-1:0]];
    end else begin
      bus.resp_data <= '0;
    end
  end

  // Router never strobes a read and a write together
  a_no_wr_and_rd: assert property (@(posedge core_ctrl_clk)
    disable iff (core_ctrl_rst)
    !(bus.wr && bus.rd));

endmodule

// ==== tb_core_kernel.sv ====
module tb_core_kernel import core_kernel_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int WORD_W       = 32;
  localparam int CFG_W        = NUM_BLOCKS * BACKEND_WIDTH;

  // Request counts per test, used to size the watchdog
  localparam int N_GLOBAL     = 5;
  localparam int N_CFG_RAND   = 20;
  localparam int N_CFG        = N_CFG_RAND + 4;
  localparam int N_STAT_RAND  = 16;
  localparam int N_STATUS     = N_STAT_RAND + 2;
  localparam int N_EDGE       = int'(NUM_EDGES) + 5;
  localparam int N_UNMAP      = 12;
  localparam int TOTAL_REQS   = N_GLOBAL + N_CFG + N_STATUS + N_EDGE + N_UNMAP;
  // Worst case is one request plus a drain, with slack for idle gaps
  localparam int WATCHDOG_NS  = (TOTAL_REQS * 8 + RESET_CYCLES + 100) * CLK_PERIOD;

  // DUT ports
  logic             core_ctrl_clk;
  logic             core_ctrl_rst;
  logic             req_wr;
  logic             req_rd;
  ctrl_addr_t       req_addr;
  ctrl_data_t       req_data;
  logic             resp_ack;
  ctrl_data_t       resp_data;
  device_id_t       device_id;
  logic [CFG_W-1:0] block_config;
  logic [CFG_W-1:0] block_status;

  // Scoreboard, one expected word per request in issue order
  ctrl_data_t exp_q [$];
  int         issued   = 0;
  int         ack_cnt  = 0;

  // Error and test bookkeeping
  int errors        = 0;
  int test_err_base = 0;
  int tests_run     = 0;
  int tests_failed  = 0;

  // Reference copy of the edge table
  ctrl_data_t edge_ref [0:NUM_EDGES];

  // Expected global identity words
  ctrl_data_t exp_protover;
  ctrl_data_t exp_port_cnt;
  ctrl_data_t exp_edge_cnt;
  ctrl_data_t exp_dev_info;
  ctrl_data_t exp_ep_cnt;

  // Config model and its one-stage write delay
  logic [CFG_W-1:0] cfg_model;
  logic             st1_wr;
  ctrl_addr_t       st1_addr;
  ctrl_data_t       st1_data;

  logic [31:0] lcg_state = 32'd92274;

  initial core_ctrl_clk = 1'b0;
  always #(CLK_PERIOD / 2) core_ctrl_clk = ~core_ctrl_clk;

  core_kernel_top dut (
    .core_ctrl_clk (core_ctrl_clk),
    .core_ctrl_rst (core_ctrl_rst),
    .req_wr        (req_wr),
    .req_rd        (req_rd),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .resp_ack      (resp_ack),
    .resp_data     (resp_data),
    .device_id     (device_id),
    .block_config  (block_config),
    .block_status  (block_status)
  );

  // -------------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------------

  function automatic ctrl_data_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Block region, slot in bits 7:6 and word in bits 5:2
  function automatic ctrl_addr_t blk_addr(input int slot, input int idx);
    return {REGION_BLOCK, 8'd0, slot[1:0], idx[3:0], 2'b00};
  endfunction

  function automatic ctrl_addr_t conn_addr(input int idx);
    return {REGION_CONN, idx[13:0], 2'b00};
  endfunction

  task automatic fill_status();
    for (int i = 0; i < CFG_W / WORD_W; i++) begin
      block_status[i*WORD_W +: WORD_W] = next_rand();
    end
  endtask

  // One strobe cycle, caller sits on a falling edge
  task automatic send(input logic wr, input ctrl_addr_t addr, input ctrl_data_t data,
                      input ctrl_data_t exp);
    req_wr   = wr;
    req_rd   = !wr;
    req_addr = addr;
    req_data = data;
    exp_q.push_back(exp);
    issued++;
    @(negedge core_ctrl_clk);
    req_wr = 1'b0;
    req_rd = 1'b0;
  endtask

  // Wait for every outstanding ack, the watchdog bounds this
  task automatic drain();
    while (ack_cnt < issued) begin
      @(negedge core_ctrl_clk);
    end
    repeat (2) @(negedge core_ctrl_clk);
  endtask

  task automatic close_test(input string name);
    int errs;
    drain();
    errs = errors - test_err_base;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("%-20s %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
    test_err_base = errors;
  endtask

  // -------------------------------------------------------------------------
  // Reference models
  // -------------------------------------------------------------------------

  always @(posedge core_ctrl_clk) begin
    if (core_ctrl_rst) begin
      ack_cnt <= 0;
    end else if (resp_ack) begin
      ack_cnt <= ack_cnt + 1;
    end
  end

  // Block writes land one edge after the sub-strobe is registered
  always @(posedge core_ctrl_clk) begin
    if (core_ctrl_rst) begin
      st1_wr <= 1'b0;
      for (int b = 0; b < NUM_BLOCKS; b++) begin
        for (int r = 0; r < REGS_PER_SLOT; r++) begin
          cfg_model[b*BACKEND_WIDTH + r*WORD_W +: WORD_W] <= CONFIG_DEFAULT[r];
        end
      end
    end else begin
      st1_wr   <= req_wr;
      st1_addr <= req_addr;
      st1_data <= req_data;
      // Only block slots show up on block_config
      if (st1_wr && st1_addr[19:16] == REGION_BLOCK && st1_addr[7:6] >= BLOCK_OFFSET) begin
        cfg_model[(st1_addr[7:6] - BLOCK_OFFSET) * BACKEND_WIDTH
                  + st1_addr[5:2] * WORD_W +: WORD_W] <= st1_data;
      end
    end
  end

  // -------------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------------

  // Exactly one ack three edges after each strobe
  a_ack_latency: assert property (@(posedge core_ctrl_clk) disable iff (core_ctrl_rst)
    resp_ack == $past(req_wr || req_rd, 3))
  else begin
    errors++;
    $display("** Error at %0t: resp_ack got %b expected %b", $time,
             $sampled(resp_ack), !$sampled(resp_ack));
  end

  a_ack_outstanding: assert property (@(posedge core_ctrl_clk) disable iff (core_ctrl_rst)
    resp_ack |-> (ack_cnt < issued))
  else begin
    errors++;
    $display("Acknowledge at %0t with no request outstanding", $time);
  end

  // In-order scoreboard compare
  a_resp_data: assert property (@(posedge core_ctrl_clk) disable iff (core_ctrl_rst)
    (resp_ack && ack_cnt < issued) |-> (resp_data == exp_q[ack_cnt]))
  else begin
    errors++;
    $display("** Error at %0t: resp_data got %h expected %h", $time,
             $sampled(resp_data), exp_q[$sampled(ack_cnt)]);
  end

  a_block_config: assert property (@(posedge core_ctrl_clk) disable iff (core_ctrl_rst)
    block_config == cfg_model)
  else begin
    errors++;
    $display("** Error at %0t: block_config got %h expected %h", $time,
             $sampled(block_config), $sampled(cfg_model));
  end

  // -------------------------------------------------------------------------
  // Stimulus
  // -------------------------------------------------------------------------

  initial begin
    ctrl_data_t r;
    int         slot;
    int         idx;
    int         b;

    core_ctrl_rst = 1'b1;
    req_wr        = 1'b0;
    req_rd        = 1'b0;
    req_addr      = '0;
    req_data      = '0;
    device_id     = 16'h5A3C;
    fill_status();
    $readmemh(EDGE_TBL_FILE, edge_ref);

    // Identity words from the register layout
    exp_protover = {CORE_SIGNATURE, PROTOVER};
    exp_port_cnt = (32'(NUM_EDGES != 0) << 31) | (32'(CHDR_XBAR_PRESENT) << 30)
                 | (32'(NUM_TRANSPORTS) << 20) | (32'(NUM_BLOCKS) << 10)
                 | 32'(NUM_STREAM_ENDPOINTS);
    exp_edge_cnt = 32'(NUM_EDGES);
    exp_dev_info = {DEVICE_TYPE, device_id};
    exp_ep_cnt   = 32'(NUM_ENDPOINTS_CTRL);

    repeat (RESET_CYCLES) @(negedge core_ctrl_clk);
    core_ctrl_rst = 1'b0;
    @(negedge core_ctrl_clk);

    // Slot 0 global registers
    send(1'b0, blk_addr(0, 0), '0, exp_protover);
    send(1'b0, blk_addr(0, 1), '0, exp_port_cnt);
    send(1'b0, blk_addr(0, 2), '0, exp_edge_cnt);
    send(1'b0, blk_addr(0, 3), '0, exp_dev_info);
    send(1'b0, blk_addr(0, 4), '0, exp_ep_cnt);
    close_test("global identity");

    // Random block writes with the odd idle gap
    for (int i = 0; i < N_CFG_RAND; i++) begin
      r    = next_rand();
      slot = BLOCK_OFFSET + int'(r[15:8]) % int'(NUM_BLOCKS);
      idx  = int'(r[3:0]);
      send(1'b1, blk_addr(slot, idx), next_rand(), '0);
      if (r[20]) begin
        @(negedge core_ctrl_clk);
      end
    end
    // Core and endpoint slots must not reach block_config
    send(1'b1, blk_addr(0, 2), next_rand(), '0);
    send(1'b1, blk_addr(1, 5), next_rand(), '0);
    send(1'b1, blk_addr(0, 15), next_rand(), '0);
    send(1'b1, blk_addr(1, 0), next_rand(), '0);
    close_test("config path");

    // Status held steady while reads are in flight
    fill_status();
    for (int i = 0; i < N_STAT_RAND; i++) begin
      r   = next_rand();
      b   = int'(r[15:8]) % int'(NUM_BLOCKS);
      idx = int'(r[3:0]);
      send(1'b0, blk_addr(BLOCK_OFFSET + b, idx), '0,
           block_status[b*BACKEND_WIDTH + idx*WORD_W +: WORD_W]);
    end
    send(1'b0, blk_addr(1, 0), '0, '0);
    send(1'b0, blk_addr(1, 9), '0, '0);
    close_test("status readback");

    // Edge table, then past the end, then a dropped write
    for (int i = 0; i <= int'(NUM_EDGES); i++) begin
      send(1'b0, conn_addr(i), '0, edge_ref[i]);
    end
    send(1'b0, conn_addr(int'(NUM_EDGES) + 1), '0, '0);
    send(1'b0, conn_addr(200), '0, '0);
    send(1'b1, conn_addr(1), 32'hDEAD_BEEF, '0);
    send(1'b0, conn_addr(1), '0, edge_ref[1]);
    close_test("edge table");

    // Unmapped regions answer zero
    send(1'b0, {4'h2, 16'h0000}, '0, '0);
    send(1'b0, {4'h7, 16'h0044}, '0, '0);
    send(1'b1, {4'hF, 16'hFFFC}, 32'h1234_5678, '0);
    send(1'b0, {4'h3, 16'h0010}, '0, '0);
    // Back-to-back burst over all three regions
    send(1'b0, blk_addr(0, 0), '0, exp_protover);
    send(1'b0, conn_addr(2), '0, edge_ref[2]);
    send(1'b0, {4'h9, 16'h0008}, '0, '0);
    send(1'b0, blk_addr(BLOCK_OFFSET + 1, 7), '0,
         block_status[BACKEND_WIDTH + 7*WORD_W +: WORD_W]);
    send(1'b1, blk_addr(BLOCK_OFFSET, 3), next_rand(), '0);
    send(1'b0, conn_addr(0), '0, edge_ref[0]);
    send(1'b0, {4'hA, 16'h0100}, '0, '0);
    send(1'b0, blk_addr(0, 2), '0, exp_edge_cnt);
    close_test("unmapped and burst");

    $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Hard stop if an ack never arrives
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, %0d of %0d acks seen", WATCHDOG_NS, ack_cnt, issued);
    $display("Done: errors found");
    $finish;
  end

endmodule
